//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module simt_core_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vsimt_core_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                decode_strobe,
    input  instr_word_t         instruction,
    output logic [OP_W-1:0]     alu_op,
    output logic [REG_W-1:0]    rd,
    output logic [REG_W-1:0]    rs1,
    output logic [REG_W-1:0]    rs2,
    output logic [DATA_W-1:0]   imm,
    output logic                reg_write,
    output logic                is_branch,
    output logic                is_store,
    output logic                is_halt
);

    logic [OP_W-1:0] opcode;
    logic imm_form;

    assign opcode   = instruction.r.opcode;
    assign imm_form = opcode inside {OP_ADDI, OP_BNZ, OP_STORE};

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op <= OP_NOP;
            reg_write <= 1'b0;
            is_branch <= 1'b0;
            is_store <= 1'b0;
            is_halt <= 1'b0;
        end else if (decode_strobe) begin
            alu_op <= opcode;
            reg_write <= opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI};
            is_branch <= (opcode == OP_BNZ);
            is_store <= (opcode == OP_STORE);
            is_halt <= (opcode == OP_HALT);
        end
    end

    always_ff @(posedge clk) begin
        if (decode_strobe) begin
            rd <= instruction.r.rd;
            rs1 <= instruction.r.rs1;
            if (imm_form) begin
                // Store data register sits in the rd slot
                rs2 <= instruction.i.rd;
                imm <= {{(DATA_W-IMM_W){instruction.i.imm[IMM_W-1]}}, instruction.i.imm};
            end else begin
                rs2 <= instruction.r.rs2;
                imm <= '0;
            end
        end
    end

endmodule

//--- source/instr_fetcher.sv
`timescale 1ns/10ps

module instr_fetcher import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [WARPS-1:0]    fetch_request,
    input  logic [PC_W-1:0]     warp_pc [WARPS],
    input  logic                imem_read_ready,
    input  instr_word_t         imem_read_data,
    output logic                imem_read_valid,
    output logic [PC_W-1:0]     imem_read_address,
    output logic                fetch_done,
    output logic [WARP_W-1:0]   fetch_warp,
    input  logic [WARP_W-1:0]   current_warp,
    output instr_word_t         instruction
);

    instr_word_t buffer [WARPS];
    logic [WARP_W-1:0] pick;
    logic pick_valid;

    // Round robin, starting after the warp served last
    always_comb begin
        int idx;
        pick = fetch_warp;
        pick_valid = 1'b0;
        for (int i = WARPS; i >= 1; i--) begin
            idx = (int'(fetch_warp) + i) % WARPS;
            if (fetch_request[idx]) begin
                pick = idx[WARP_W-1:0];
                pick_valid = 1'b1;
            end
        end
    end

    assign fetch_done = imem_read_valid && imem_read_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            imem_read_valid <= 1'b0;
            fetch_warp <= '0;
        end else if (imem_read_valid) begin
            if (imem_read_ready) imem_read_valid <= 1'b0;
        end else if (pick_valid) begin
            imem_read_valid <= 1'b1;
            fetch_warp <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (!imem_read_valid && pick_valid) imem_read_address <= warp_pc[pick];
        if (fetch_done) buffer[fetch_warp] <= imem_read_data;
    end

    assign instruction = buffer[current_warp];

endmodule

//--- source/simt_core.sv
`timescale 1ns/10ps

module simt_core import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [PC_W-1:0]     base_pc,
    output logic                done,
    output logic                imem_read_valid,
    output logic [PC_W-1:0]     imem_read_address,
    input  logic                imem_read_ready,
    input  instr_word_t         imem_read_data,
    output logic [LANES-1:0]    dmem_write_valid,
    output logic [DATA_W-1:0]   dmem_write_address [LANES],
    output logic [DATA_W-1:0]   dmem_write_data [LANES],
    input  logic [LANES-1:0]    dmem_write_ready
);

    // Scheduler and fetch
    logic [WARPS-1:0] fetch_request;
    logic [PC_W-1:0] warp_pc [WARPS];
    logic fetch_done;
    logic [WARP_W-1:0] fetch_warp;
    logic [WARP_W-1:0] current_warp;
    instr_word_t instruction;
    logic decode_strobe;
    logic exec_strobe;
    logic store_strobe;

    // Decoded fields
    logic [OP_W-1:0] alu_op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [DATA_W-1:0] imm;
    logic reg_write;
    logic is_branch;
    logic is_store;
    logic is_halt;

    // Lane datapath
    logic [DATA_W-1:0] rs1_data [LANES];
    logic [DATA_W-1:0] rs2_data [LANES];
    logic [DATA_W-1:0] write_data [LANES];
    logic write_enable;
    logic branch_taken;
    logic store_busy;

    warp_scheduler u_scheduler (
        .clk(clk), .reset(reset), .start(start), .base_pc(base_pc),
        .fetch_done(fetch_done), .fetch_warp(fetch_warp),
        .is_branch(is_branch), .is_store(is_store), .is_halt(is_halt), .imm(imm),
        .branch_taken(branch_taken), .store_busy(store_busy),
        .fetch_request(fetch_request), .warp_pc(warp_pc), .current_warp(current_warp),
        .decode_strobe(decode_strobe), .exec_strobe(exec_strobe),
        .store_strobe(store_strobe), .done(done)
    );

    instr_fetcher u_fetcher (
        .clk(clk), .reset(reset), .fetch_request(fetch_request), .warp_pc(warp_pc),
        .imem_read_ready(imem_read_ready), .imem_read_data(imem_read_data),
        .imem_read_valid(imem_read_valid), .imem_read_address(imem_read_address),
        .fetch_done(fetch_done), .fetch_warp(fetch_warp),
        .current_warp(current_warp), .instruction(instruction)
    );

    instr_decoder u_decoder (
        .clk(clk), .reset(reset), .decode_strobe(decode_strobe), .instruction(instruction),
        .alu_op(alu_op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .reg_write(reg_write),
        .is_branch(is_branch), .is_store(is_store), .is_halt(is_halt)
    );

    vector_reg_file u_reg_file (
        .clk(clk), .reset(reset), .current_warp(current_warp),
        .rs1(rs1), .rs2(rs2), .rd(rd), .write_enable(write_enable),
        .write_data(write_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    vector_exec u_exec (
        .clk(clk), .reset(reset), .exec_strobe(exec_strobe), .store_strobe(store_strobe),
        .alu_op(alu_op), .imm(imm), .reg_write(reg_write),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .write_enable(write_enable), .write_data(write_data),
        .branch_taken(branch_taken), .store_busy(store_busy),
        .dmem_write_valid(dmem_write_valid), .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data), .dmem_write_ready(dmem_write_ready)
    );

endmodule

//--- source/simt_pkg.sv
package simt_pkg;

    // Core geometry
    localparam int WARPS    = 2;
    localparam int LANES    = 4;
    localparam int WARP_W   = 1;
    localparam int DATA_W   = 32;
    localparam int PC_W     = 8;
    localparam int NUM_REGS = 16;

    // Instruction field widths
    localparam int REG_W = 4;
    localparam int OP_W  = 4;
    localparam int IMM_W = 20;

    // Register 0 reads zero, register 1 holds the thread id
    localparam logic [REG_W-1:0] REG_TID = 4'd1;

    localparam logic [OP_W-1:0] OP_NOP   = 4'd0;
    localparam logic [OP_W-1:0] OP_ADD   = 4'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 4'd2;
    localparam logic [OP_W-1:0] OP_AND   = 4'd3;
    localparam logic [OP_W-1:0] OP_OR    = 4'd4;
    localparam logic [OP_W-1:0] OP_ADDI  = 4'd5;
    localparam logic [OP_W-1:0] OP_BNZ   = 4'd6;
    localparam logic [OP_W-1:0] OP_STORE = 4'd7;
    localparam logic [OP_W-1:0] OP_HALT  = 4'd8;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        STORE_WAIT,
        UPDATE,
        DONE
    } warp_state_t;

    // Same word, register form or immediate form
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]                    opcode;
            logic [REG_W-1:0]                   rd;
            logic [REG_W-1:0]                   rs1;
            logic [REG_W-1:0]                   rs2;
            logic [DATA_W-OP_W-3*REG_W-1:0]     unused;
        } r;
        struct packed {
            logic [OP_W-1:0]    opcode;
            logic [REG_W-1:0]   rd;
            logic [REG_W-1:0]   rs1;
            logic [IMM_W-1:0]   imm;
        } i;
    } instr_word_t;

endpackage

//--- source/vector_exec.sv
`timescale 1ns/10ps

module vector_exec import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                exec_strobe,
    input  logic                store_strobe,
    input  logic [OP_W-1:0]     alu_op,
    input  logic [DATA_W-1:0]   imm,
    input  logic                reg_write,
    input  logic [DATA_W-1:0]   rs1_data [LANES],
    input  logic [DATA_W-1:0]   rs2_data [LANES],
    output logic                write_enable,
    output logic [DATA_W-1:0]   write_data [LANES],
    output logic                branch_taken,
    output logic                store_busy,
    output logic [LANES-1:0]    dmem_write_valid,
    output logic [DATA_W-1:0]   dmem_write_address [LANES],
    output logic [DATA_W-1:0]   dmem_write_data [LANES],
    input  logic [LANES-1:0]    dmem_write_ready
);

    assign write_enable = exec_strobe && reg_write;
    // Lane 0 decides for the whole warp
    assign branch_taken = (rs1_data[0] != '0);
    assign store_busy   = |dmem_write_valid;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            case (alu_op)
                OP_ADD:  write_data[l] = rs1_data[l] + rs2_data[l];
                OP_SUB:  write_data[l] = rs1_data[l] - rs2_data[l];
                OP_AND:  write_data[l] = rs1_data[l] & rs2_data[l];
                OP_OR:   write_data[l] = rs1_data[l] | rs2_data[l];
                OP_ADDI: write_data[l] = rs1_data[l] + imm;
                default: write_data[l] = '0;
            endcase
        end
    end

    // One write requester per lane, each released by its own ready
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (reset) dmem_write_valid[l] <= 1'b0;
            else if (store_strobe) dmem_write_valid[l] <= 1'b1;
            else if (dmem_write_valid[l] && dmem_write_ready[l]) dmem_write_valid[l] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_strobe) begin
            for (int l = 0; l < LANES; l++) begin
                dmem_write_address[l] <= rs1_data[l] + imm;
                dmem_write_data[l] <= rs2_data[l];
            end
        end
    end

endmodule

//--- source/vector_reg_file.sv
`timescale 1ns/10ps

module vector_reg_file import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [WARP_W-1:0]   current_warp,
    input  logic [REG_W-1:0]    rs1,
    input  logic [REG_W-1:0]    rs2,
    input  logic [REG_W-1:0]    rd,
    input  logic                write_enable,
    input  logic [DATA_W-1:0]   write_data [LANES],
    output logic [DATA_W-1:0]   rs1_data [LANES],
    output logic [DATA_W-1:0]   rs2_data [LANES]
);

    logic [DATA_W-1:0] read1 [WARPS][LANES];
    logic [DATA_W-1:0] read2 [WARPS][LANES];
    logic writable;

    // Registers 0 and TID are read-only
    assign writable = write_enable && (rd != '0) && (rd != REG_TID);

    for (genvar w = 0; w < WARPS; w++) begin : g_warp
        for (genvar l = 0; l < LANES; l++) begin : g_lane
            localparam logic [DATA_W-1:0] TID = DATA_W'(w * LANES + l);
            logic [DATA_W-1:0] regs [NUM_REGS];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int r = 0; r < NUM_REGS; r++) regs[r] <= '0;
                end else if (writable && current_warp == w) begin
                    regs[rd] <= write_data[l];
                end
            end

            assign read1[w][l] = (rs1 == '0) ? '0 : (rs1 == REG_TID) ? TID : regs[rs1];
            assign read2[w][l] = (rs2 == '0) ? '0 : (rs2 == REG_TID) ? TID : regs[rs2];
        end
    end

    for (genvar l = 0; l < LANES; l++) begin : g_read
        assign rs1_data[l] = read1[current_warp][l];
        assign rs2_data[l] = read2[current_warp][l];
    end

endmodule

//--- source/warp_scheduler.sv
`timescale 1ns/10ps

module warp_scheduler import simt_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [PC_W-1:0]     base_pc,
    input  logic                fetch_done,
    input  logic [WARP_W-1:0]   fetch_warp,
    input  logic                is_branch,
    input  logic                is_store,
    input  logic                is_halt,
    input  logic [DATA_W-1:0]   imm,
    input  logic                branch_taken,
    input  logic                store_busy,
    output logic [WARPS-1:0]    fetch_request,
    output logic [PC_W-1:0]     warp_pc [WARPS],
    output logic [WARP_W-1:0]   current_warp,
    output logic                decode_strobe,
    output logic                exec_strobe,
    output logic                store_strobe,
    output logic                done
);

    warp_state_t state [WARPS];
    warp_state_t cur_state;
    logic [PC_W-1:0] next_pc;
    logic all_done;
    logic [WARP_W-1:0] pick;
    logic pick_valid;

    assign cur_state     = state[current_warp];
    assign decode_strobe = (cur_state == DECODE);
    assign exec_strobe   = (cur_state == EXECUTE);
    assign store_strobe  = exec_strobe && is_store;

    always_comb begin
        all_done = 1'b1;
        for (int w = 0; w < WARPS; w++) begin
            fetch_request[w] = (state[w] == FETCH);
            if (state[w] != DONE) all_done = 1'b0;
        end
    end

    // Nearest warp after the current one that waits for the execute slot
    always_comb begin
        int idx;
        pick = current_warp;
        pick_valid = 1'b0;
        for (int i = WARPS; i >= 1; i--) begin
            idx = (int'(current_warp) + i) % WARPS;
            if (!(state[idx] inside {IDLE, FETCH, DONE})) begin
                pick = idx[WARP_W-1:0];
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS; w++) state[w] <= IDLE;
            current_warp <= '0;
            done <= 1'b0;
        end else if (start) begin
            for (int w = 0; w < WARPS; w++) state[w] <= FETCH;
            current_warp <= '0;
            done <= 1'b0;
        end else begin
            done <= all_done;
            // Fetches complete in parallel with execution
            if (fetch_done && state[fetch_warp] == FETCH) state[fetch_warp] <= DECODE;
            if ((cur_state == UPDATE || cur_state == DONE) && pick_valid) current_warp <= pick;
            case (cur_state)
                DECODE:     state[current_warp] <= EXECUTE;
                EXECUTE:    state[current_warp] <= is_store ? STORE_WAIT : UPDATE;
                STORE_WAIT: if (!store_busy) state[current_warp] <= UPDATE;
                UPDATE:     state[current_warp] <= is_halt ? DONE : FETCH;
                default: ;
            endcase
        end
    end

    // Branch outcome is only valid in EXECUTE, so the target is kept until UPDATE
    always_ff @(posedge clk) begin
        if (start) begin
            for (int w = 0; w < WARPS; w++) warp_pc[w] <= base_pc;
        end else if (cur_state == UPDATE) begin
            warp_pc[current_warp] <= next_pc;
        end
        if (exec_strobe) begin
            if (is_branch && branch_taken) next_pc <= warp_pc[current_warp] + imm[PC_W-1:0];
            else next_pc <= warp_pc[current_warp] + PC_W'(1);
        end
    end

endmodule

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Entry points of the two test programs
localparam logic [PC_W-1:0] ARITH_BASE = 8'd0;
localparam logic [PC_W-1:0] LOOP_BASE  = 8'd16;

function automatic instr_word_t encode_reg(logic [OP_W-1:0] op, int rd, int rs1, int rs2);
    instr_word_t w;
    w.r.opcode = op;
    w.r.rd     = REG_W'(rd);
    w.r.rs1    = REG_W'(rs1);
    w.r.rs2    = REG_W'(rs2);
    w.r.unused = '0;
    return w;
endfunction

function automatic instr_word_t encode_imm(logic [OP_W-1:0] op, int rd, int rs1, int imm);
    instr_word_t w;
    w.i.opcode = op;
    w.i.rd     = REG_W'(rd);
    w.i.rs1    = REG_W'(rs1);
    w.i.imm    = IMM_W'(imm);
    return w;
endfunction

// Arithmetic program at 0, branch loop at 16, halt words tagged with their address elsewhere
function automatic instr_word_t program_word(int addr);
    instr_word_t w;
    case (addr)
        0:  w = encode_imm(OP_ADDI, 2, 1, 3);
        1:  w = encode_reg(OP_ADD, 3, 2, 1);
        2:  w = encode_reg(OP_SUB, 4, 1, 3);
        3:  w = encode_reg(OP_AND, 5, 3, 2);
        4:  w = encode_reg(OP_OR, 6, 5, 4);
        5:  w = encode_imm(OP_STORE, 6, 1, 16);
        6:  w = encode_imm(OP_STORE, 3, 1, 32);
        16: w = encode_imm(OP_ADDI, 2, 1, 2);
        17: w = encode_imm(OP_ADDI, 3, 0, 0);
        // Loop body, r3 counts trips and r2 counts down
        18: w = encode_imm(OP_ADDI, 3, 3, 1);
        19: w = encode_imm(OP_ADDI, 2, 2, -1);
        20: w = encode_imm(OP_BNZ, 0, 2, -2);
        21: w = encode_imm(OP_STORE, 3, 1, 64);
        22: w = encode_imm(OP_STORE, 2, 1, 80);
        default: w = {OP_HALT, 28'(addr)};
    endcase
    return w;
endfunction

// k-th store of thread tid in the arithmetic program
function automatic logic [DATA_W-1:0] arith_expected(int tid, int k);
    logic [DATA_W-1:0] r2;
    logic [DATA_W-1:0] r3;
    logic [DATA_W-1:0] r4;
    logic [DATA_W-1:0] r6;
    r2 = DATA_W'(tid + 3);
    r3 = r2 + DATA_W'(tid);
    r4 = DATA_W'(tid) - r3;
    r6 = (r3 & r2) | r4;
    return (k == 0) ? r6 : r3;
endfunction

// Lane 0's counter sets the trip count of the whole warp
function automatic int loop_trips(int warp);
    return warp * LANES + 2;
endfunction

function automatic logic [DATA_W-1:0] loop_expected(int tid, int k);
    int trips;
    trips = loop_trips(tid / LANES);
    return (k == 0) ? DATA_W'(trips) : DATA_W'(tid + 2 - trips);
endfunction

function automatic int store_address(logic [PC_W-1:0] base, int tid, int k);
    return tid + ((base == LOOP_BASE) ? 64 : 16) + 16 * k;
endfunction

// Instructions executed by all warps in one run
function automatic int program_length(logic [PC_W-1:0] base);
    int total;
    total = 0;
    for (int w = 0; w < WARPS; w++) begin
        total += (base == LOOP_BASE) ? 5 + 3 * loop_trips(w) : 8;
    end
    return total;
endfunction

`endif

//--- verif/simt_core_tb.sv
`timescale 1ns/10ps

module simt_core_tb import simt_pkg::*; ();

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int SEED = 32'h78137fe9;
    localparam int RUN_STORES = 2 * WARPS * LANES;

    logic clk;
    logic reset;
    logic start;
    logic [PC_W-1:0] base_pc;
    logic done;
    logic imem_read_valid;
    logic [PC_W-1:0] imem_read_address;
    logic imem_read_ready;
    instr_word_t imem_read_data;
    logic [LANES-1:0] dmem_write_valid;
    logic [DATA_W-1:0] dmem_write_address [LANES];
    logic [DATA_W-1:0] dmem_write_data [LANES];
    logic [LANES-1:0] dmem_write_ready;

    instr_word_t imem [IMEM_WORDS];
    logic [DATA_W-1:0] exp_data [DMEM_WORDS];
    logic exp_valid [DMEM_WORDS];
    logic written [DMEM_WORDS];
    // Data of the first arithmetic run, for the rerun
    logic [DATA_W-1:0] first_arith [DMEM_WORDS];
    logic arith_seen;
    logic [PC_W-1:0] run_base;
    int imem_delay;
    int dmem_delay [LANES];
    int stores_seen;
    int stores_total;
    int halt_fetches;
    int mismatch_count;
    int error_count;
    int cycle_count;
    int cycle_limit;

    `include "tb_program.svh"

    tb_clock_gen u_clock (.clk(clk));

    simt_core UUT (
        .clk(clk), .reset(reset), .start(start), .base_pc(base_pc), .done(done),
        .imem_read_valid(imem_read_valid), .imem_read_address(imem_read_address),
        .imem_read_ready(imem_read_ready), .imem_read_data(imem_read_data),
        .dmem_write_valid(dmem_write_valid), .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data), .dmem_write_ready(dmem_write_ready)
    );

    task automatic print_counts();
        $display("Summary: %0d stores checked, %0d mismatches, %0d other errors",
            stores_total, mismatch_count, error_count);
    endtask

    // Called when the data memory accepts a lane's write
    task automatic check_write(input int lane, input logic [DATA_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        int a;
        logic ok;
        a = int'(addr % DMEM_WORDS);
        ok = (addr < DMEM_WORDS) && exp_valid[a] && !written[a];
        assert (ok) else begin
            error_count++;
            $display("Unexpected or repeated store at %0t: lane %0d address %0d",
                $time, lane, addr);
        end
        if (ok) begin
            written[a] = 1'b1;
            stores_seen++;
            stores_total++;
            assert (data == exp_data[a]) else begin
                mismatch_count++;
                $display("Mismatch at %0t: lane %0d address %0d wrote %h, expected %h",
                    $time, lane, addr, data, exp_data[a]);
            end
            if (run_base == ARITH_BASE && !arith_seen) begin
                first_arith[a] = data;
            end else if (run_base == ARITH_BASE) begin
                assert (data == first_arith[a]) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: rerun wrote %h to address %0d, first run %h",
                        $time, data, addr, first_arith[a]);
                end
            end
        end
    endtask

    task automatic run_program(input logic [PC_W-1:0] base);
        for (int a = 0; a < DMEM_WORDS; a++) begin
            exp_valid[a] = 1'b0;
            written[a] = 1'b0;
        end
        for (int t = 0; t < WARPS * LANES; t++) begin
            for (int k = 0; k < 2; k++) begin
                exp_valid[store_address(base, t, k)] = 1'b1;
                exp_data[store_address(base, t, k)] =
                    (base == LOOP_BASE) ? loop_expected(t, k) : arith_expected(t, k);
            end
        end
        run_base = base;
        stores_seen = 0;
        halt_fetches = 0;
        @(negedge clk);
        base_pc = base;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
        assert (stores_seen == RUN_STORES && halt_fetches == WARPS && dmem_write_valid == '0)
        else begin
            error_count++;
            $display("done rose at %0t after %0d of %0d stores and %0d halt fetches",
                $time, stores_seen, RUN_STORES, halt_fetches);
        end
        if (base == ARITH_BASE) arith_seen = 1'b1;
        // Idle while done must hold
        repeat (4) @(negedge clk);
    endtask

    // Instruction memory with a random ready delay
    always @(negedge clk) begin
        if (reset) begin
            imem_read_ready <= 1'b0;
        end else if (imem_read_ready) begin
            imem_read_ready <= 1'b0;
            imem_delay <= $urandom_range(3, 0);
        end else if (imem_read_valid && imem_delay > 0) begin
            imem_delay <= imem_delay - 1;
        end else if (imem_read_valid) begin
            imem_read_ready <= 1'b1;
            imem_read_data <= imem[imem_read_address];
            if (imem[imem_read_address].r.opcode == OP_HALT) halt_fetches++;
        end
    end

    // One data memory port per lane
    always @(negedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (reset) begin
                dmem_write_ready[l] <= 1'b0;
            end else if (dmem_write_ready[l]) begin
                dmem_write_ready[l] <= 1'b0;
                dmem_delay[l] <= $urandom_range(3, 0);
            end else if (dmem_write_valid[l] && dmem_delay[l] > 0) begin
                dmem_delay[l] <= dmem_delay[l] - 1;
            end else if (dmem_write_valid[l]) begin
                dmem_write_ready[l] <= 1'b1;
                check_write(l, dmem_write_address[l], dmem_write_data[l]);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        imem_read_valid && !imem_read_ready |=> imem_read_valid && $stable(imem_read_address))
    else begin
        error_count++;
        $display("Instruction request dropped or moved before ready at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        imem_read_valid && imem_read_ready |=> !imem_read_valid)
    else begin
        error_count++;
        $display("Instruction valid still high after the handshake at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (reset) done && !start |=> done)
    else begin
        error_count++;
        $display("done fell without a start at %0t", $time);
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane_check
        assert property (@(posedge clk) disable iff (reset)
            dmem_write_valid[l] && !dmem_write_ready[l] |=> dmem_write_valid[l]
            && $stable(dmem_write_address[l]) && $stable(dmem_write_data[l]))
        else begin
            error_count++;
            $display("Lane %0d write dropped or changed before ready at %0t", l, $time);
        end

        assert property (@(posedge clk) disable iff (reset)
            dmem_write_valid[l] && dmem_write_ready[l] |=> !dmem_write_valid[l])
        else begin
            error_count++;
            $display("Lane %0d write valid still high after the handshake at %0t", l, $time);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles without done", cycle_count);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        start = 1'b0;
        base_pc = '0;
        imem_read_ready = 1'b0;
        imem_read_data = '0;
        dmem_write_ready = '0;
        imem_delay = 0;
        for (int l = 0; l < LANES; l++) dmem_delay[l] = 0;
        stores_seen = 0;
        stores_total = 0;
        halt_fetches = 0;
        mismatch_count = 0;
        error_count = 0;
        cycle_count = 0;
        arith_seen = 1'b0;
        run_base = ARITH_BASE;
        for (int a = 0; a < IMEM_WORDS; a++) imem[a] = program_word(a);
        // Arithmetic twice, loop once
        cycle_limit = 40 * (2 * program_length(ARITH_BASE) + program_length(LOOP_BASE)) + 200;

        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!done && !imem_read_valid && dmem_write_valid == '0) else begin
                error_count++;
                $display("Outputs active before the first start at %0t", $time);
            end
        end

        run_program(ARITH_BASE);
        run_program(LOOP_BASE);
        run_program(ARITH_BASE);

        print_counts();
        if (mismatch_count == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- vlog.f
+incdir+include
source/simt_pkg.sv
source/warp_scheduler.sv
source/instr_fetcher.sv
source/instr_decoder.sv
source/vector_reg_file.sv
source/vector_exec.sv
source/simt_core.sv
verif/tb_clock_gen.sv
verif/simt_core_tb.sv
